// File: Bender.yml
package:
  name: a2_hdmi_audio

sources:
  # Shared package first, then the RTL blocks and the top level
  - design/a2_audio_pkg.sv
  - design/phase_sync.sv
  - design/speaker_switch.sv
  - design/audio_tick_gen.sv
  - design/speaker_pulse_limiter.sv
  - design/audio_sample_mixer.sv
  - design/a2_audio_top.sv

  # Bound assertions and the testbench top tb_a2_audio
  - target: test
    files:
      - verif/a2_audio_props.sv
      - verif/tb_a2_audio.sv

// File: design/a2_audio_pkg.sv
package a2_audio_pkg;

    // Apple II bus
    localparam int ADDR_W = 16;

    // Speaker soft switch, any access toggles the speaker
    localparam logic [ADDR_W-1:0] SPEAKER_ADDR = 16'hC030;

    // Mockingboard channel width as delivered by the synthesizer
    localparam int MB_AUDIO_W = 10;

    // HDMI audio sample width
    localparam int SAMPLE_W = 16;

    // Position of a Mockingboard channel inside a sample
    localparam int MB_SHIFT = 4;

    // Amount a sounding speaker adds to each sample
    localparam logic [SAMPLE_W-1:0] SPEAKER_LEVEL = 16'h2000;

    // Speaker pulse length counter, in audio ticks
    localparam int PULSE_W = 8;

    // Loaded on every speaker change, so a held level
    // sounds for at most this many ticks
    localparam logic [PULSE_W-1:0] PULSE_MAX = 8'd255;

endpackage

// File: design/a2_audio_top.sv
module a2_audio_top #(
    parameter int CLOCK_SPEED_HZ = 27_000_000,
    parameter int AUDIO_RATE     = 44100,
    parameter bit SPEAKER_ENABLE = 1'b1
) (
    input  logic                                clk_pixel_w,
    input  logic                                system_reset_n_w,

    // Apple II bus that the card only snoops
    input  logic                                a2_phi1_i,
    input  logic [a2_audio_pkg::ADDR_W-1:0]     a2_addr_i,
    input  logic                                a2_m2sel_n_i,

    // Mockingboard channels
    input  logic [a2_audio_pkg::MB_AUDIO_W-1:0] mb_audio_l_i,
    input  logic [a2_audio_pkg::MB_AUDIO_W-1:0] mb_audio_r_i,

    // HDMI audio samples
    output logic [a2_audio_pkg::SAMPLE_W-1:0]   sample_l_o,
    output logic [a2_audio_pkg::SAMPLE_W-1:0]   sample_r_o,
    output logic                                sample_valid_o
);

    logic phi1_rise_w;
    logic speaker_bit_w;
    logic audio_tick_w;
    logic speaker_pulse_w;

    // Phi1 into the pixel clock domain.
    // Only the rising edge drives the bus decode here
    phase_sync i_phase_sync_phi1 (
        .clk_pixel_w      (clk_pixel_w),
        .system_reset_n_w (system_reset_n_w),
        .async_i          (a2_phi1_i),
        .rise_o           (phi1_rise_w),
        .fall_o           ()
    );

    // Speaker soft switch at C030
    speaker_switch i_speaker_switch (
        .clk_pixel_w      (clk_pixel_w),
        .system_reset_n_w (system_reset_n_w),
        .phi1_rise_i      (phi1_rise_w),
        .addr_i           (a2_addr_i),
        .m2sel_n_i        (a2_m2sel_n_i),
        .speaker_bit_o    (speaker_bit_w)
    );

    // Sample rate strobe
    audio_tick_gen #(
        .CLOCK_SPEED_HZ (CLOCK_SPEED_HZ),
        .AUDIO_RATE     (AUDIO_RATE)
    ) i_audio_tick_gen (
        .clk_pixel_w      (clk_pixel_w),
        .system_reset_n_w (system_reset_n_w),
        .tick_o           (audio_tick_w)
    );

    // Held speaker level becomes a bounded pulse
    speaker_pulse_limiter #(
        .SPEAKER_ENABLE (SPEAKER_ENABLE)
    ) i_speaker_pulse_limiter (
        .clk_pixel_w      (clk_pixel_w),
        .system_reset_n_w (system_reset_n_w),
        .tick_i           (audio_tick_w),
        .speaker_bit_i    (speaker_bit_w),
        .pulse_o          (speaker_pulse_w)
    );

    // Speaker and Mockingboard mixed into one sample pair per tick
    audio_sample_mixer i_audio_sample_mixer (
        .clk_pixel_w      (clk_pixel_w),
        .system_reset_n_w (system_reset_n_w),
        .tick_i           (audio_tick_w),
        .speaker_i        (speaker_pulse_w),
        .mb_l_i           (mb_audio_l_i),
        .mb_r_i           (mb_audio_r_i),
        .sample_l_o       (sample_l_o),
        .sample_r_o       (sample_r_o),
        .sample_valid_o   (sample_valid_o)
    );

endmodule

// File: design/audio_sample_mixer.sv
module audio_sample_mixer (
    input  logic                              clk_pixel_w,
    input  logic                              system_reset_n_w,
    input  logic                              tick_i,
    input  logic                              speaker_i,
    input  logic [a2_audio_pkg::MB_AUDIO_W-1:0] mb_l_i,
    input  logic [a2_audio_pkg::MB_AUDIO_W-1:0] mb_r_i,
    output logic [a2_audio_pkg::SAMPLE_W-1:0]   sample_l_o,
    output logic [a2_audio_pkg::SAMPLE_W-1:0]   sample_r_o,
    output logic                              sample_valid_o
);

    import a2_audio_pkg::*;

    logic [SAMPLE_W-1:0] speaker_term_w;
    logic [SAMPLE_W-1:0] sample_l_r;
    logic [SAMPLE_W-1:0] sample_r_r;
    logic                valid_r;

    // Channel placed in the sample word with headroom for the speaker
    function automatic logic [SAMPLE_W-1:0] mix_channel(
        input logic [MB_AUDIO_W-1:0] mb,
        input logic [SAMPLE_W-1:0]   speaker_term
    );
        logic [SAMPLE_W-1:0] shifted;
        shifted = SAMPLE_W'(mb) << MB_SHIFT;
        return shifted + speaker_term;
    endfunction

    assign speaker_term_w = speaker_i ? SPEAKER_LEVEL : '0;

    // Sample pair captured on a tick and held until the next one
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            sample_l_r <= '0;
            sample_r_r <= '0;
        end else if (tick_i) begin
            sample_l_r <= mix_channel(mb_l_i, speaker_term_w);
            sample_r_r <= mix_channel(mb_r_i, speaker_term_w);
        end
    end

    // Valid strobe one clock behind the capture, no back-pressure
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= tick_i;
        end
    end

    assign sample_l_o     = sample_l_r;
    assign sample_r_o     = sample_r_r;
    assign sample_valid_o = valid_r;

endmodule

// File: design/audio_tick_gen.sv
module audio_tick_gen #(
    parameter int CLOCK_SPEED_HZ = 27_000_000,
    parameter int AUDIO_RATE     = 44100
) (
    input  logic clk_pixel_w,
    input  logic system_reset_n_w,
    output logic tick_o
);

    // Clocks per audio sample
    localparam int AUDIO_DIVIDE = CLOCK_SPEED_HZ / AUDIO_RATE;
    localparam int CNT_W        = (AUDIO_DIVIDE > 2) ? $clog2(AUDIO_DIVIDE) : 1;

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(AUDIO_DIVIDE - 1);

    logic [CNT_W-1:0] count_r;
    logic             wrap_w;
    logic             tick_r;

    assign wrap_w = (count_r == CNT_LAST);

    // Wrapping counter, 0 up to AUDIO_DIVIDE-1
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            count_r <= '0;
        end else if (wrap_w) begin
            count_r <= '0;
        end else begin
            count_r <= count_r + 1'b1;
        end
    end

    // Registered strobe on wrap, so the first one lands
    // AUDIO_DIVIDE clocks after reset release
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            tick_r <= 1'b0;
        end else begin
            tick_r <= wrap_w;
        end
    end

    assign tick_o = tick_r;

endmodule

// File: design/phase_sync.sv
module phase_sync (
    input  logic clk_pixel_w,
    input  logic system_reset_n_w,
    input  logic async_i,
    output logic rise_o,
    output logic fall_o
);

    // Two synchronizer stages, then the previous synchronized value
    logic sync_meta_r;
    logic sync_r;
    logic prev_r;

    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            sync_meta_r <= 1'b0;
            sync_r      <= 1'b0;
            prev_r      <= 1'b0;
        end else begin
            sync_meta_r <= async_i;
            sync_r      <= sync_meta_r;
            prev_r      <= sync_r;
        end
    end

    // Edge strobes, each high for exactly one clock
    assign rise_o = sync_r & ~prev_r;
    assign fall_o = ~sync_r & prev_r;

endmodule

// File: design/speaker_pulse_limiter.sv
module speaker_pulse_limiter #(
    parameter bit SPEAKER_ENABLE = 1'b1
) (
    input  logic clk_pixel_w,
    input  logic system_reset_n_w,
    input  logic tick_i,
    input  logic speaker_bit_i,
    output logic pulse_o
);

    import a2_audio_pkg::*;

    // The Apple II speaker is a level that sits high or low indefinitely.
    // Passed straight to HDMI that level becomes a DC offset, so each
    // change only sounds for a limited number of sample periods.

    logic               prev_bit_r;
    logic [PULSE_W-1:0] count_r;
    logic               pulse_r;
    logic               changed_w;
    logic               active_w;

    assign changed_w = (speaker_bit_i != prev_bit_r);

    // Pulse decision uses the state from before this tick
    assign active_w = prev_bit_r && (count_r != '0);

    // Remaining pulse length, reloaded on every speaker change
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            count_r <= '0;
        end else if (tick_i) begin
            if (changed_w) begin
                count_r <= PULSE_MAX;
            end else if (count_r != '0) begin
                count_r <= count_r - 1'b1;
            end
        end
    end

    // Copy of the speaker bit as seen at the previous tick
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            prev_bit_r <= 1'b0;
        end else if (tick_i) begin
            prev_bit_r <= speaker_bit_i;
        end
    end

    // Output only moves on ticks, a muted build holds it low
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            pulse_r <= 1'b0;
        end else if (tick_i) begin
            pulse_r <= active_w && SPEAKER_ENABLE;
        end
    end

    assign pulse_o = pulse_r;

endmodule

// File: design/speaker_switch.sv
module speaker_switch (
    input  logic                          clk_pixel_w,
    input  logic                          system_reset_n_w,
    input  logic                          phi1_rise_i,
    input  logic [a2_audio_pkg::ADDR_W-1:0] addr_i,
    input  logic                          m2sel_n_i,
    output logic                          speaker_bit_o
);

    import a2_audio_pkg::*;

    logic speaker_hit_w;
    logic speaker_bit_r;

    // The bus is sampled once per bus cycle, on the Phi1 rise strobe.
    // Reads and writes both count, the real hardware toggles on either
    assign speaker_hit_w = phi1_rise_i && (addr_i == SPEAKER_ADDR) && !m2sel_n_i;

    // One-bit sound source of the Apple II
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            speaker_bit_r <= 1'b0;
        end else if (speaker_hit_w) begin
            speaker_bit_r <= ~speaker_bit_r;
        end
    end

    assign speaker_bit_o = speaker_bit_r;

endmodule

// File: src.f
design/a2_audio_pkg.sv
design/phase_sync.sv
design/speaker_switch.sv
design/audio_tick_gen.sv
design/speaker_pulse_limiter.sv
design/audio_sample_mixer.sv
design/a2_audio_top.sv
verif/a2_audio_props.sv
verif/tb_a2_audio.sv

// File: verif/a2_audio_props.sv
module a2_audio_props #(
    parameter int AUDIO_DIVIDE  = 0,
    parameter bit CHECK_SAMPLES = 1'b0
) (
    input logic                              clk_pixel_w,
    input logic                              system_reset_n_w,
    input logic                              tick_i,
    input logic                              sample_valid_i,
    input logic [a2_audio_pkg::SAMPLE_W-1:0] sample_l_i,
    input logic [a2_audio_pkg::SAMPLE_W-1:0] sample_r_i
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int GAP = (AUDIO_DIVIDE > 1) ? AUDIO_DIVIDE - 1 : 1;

    // Everything sits at zero while reset is held
    reset_state_a: assert property (@(posedge clk_pixel_w)
        !system_reset_n_w |-> (!tick_i && !sample_valid_i &&
                               sample_l_i == '0 && sample_r_i == '0))
        else $error("outputs not zero during reset");

    if (AUDIO_DIVIDE > 1) begin : g_tick_spacing
        tick_spacing_a: assert property (@(posedge clk_pixel_w)
            disable iff (!system_reset_n_w)
            tick_i |=> !tick_i [*GAP] ##1 tick_i)
            else $error("audio ticks not %0d cycles apart", AUDIO_DIVIDE);
    end

    if (CHECK_SAMPLES) begin : g_sample_strobe
        valid_single_a: assert property (@(posedge clk_pixel_w)
            disable iff (!system_reset_n_w)
            sample_valid_i |=> !sample_valid_i)
            else $error("sample strobe high for two cycles");

        // Strobe trails the capture tick by exactly one clock
        valid_after_tick_a: assert property (@(posedge clk_pixel_w)
            disable iff (!system_reset_n_w)
            tick_i |=> sample_valid_i)
            else $error("no sample strobe after a tick");

        valid_needs_tick_a: assert property (@(posedge clk_pixel_w)
            disable iff (!system_reset_n_w)
            sample_valid_i |-> $past(tick_i))
            else $error("sample strobe without a tick before it");
    end

endmodule

bind audio_tick_gen a2_audio_props #(
    .AUDIO_DIVIDE  (CLOCK_SPEED_HZ / AUDIO_RATE),
    .CHECK_SAMPLES (1'b0)
) i_tick_props (
    .clk_pixel_w      (clk_pixel_w),
    .system_reset_n_w (system_reset_n_w),
    .tick_i           (tick_o),
    .sample_valid_i   (1'b0),
    .sample_l_i       ('0),
    .sample_r_i       ('0)
);

bind audio_sample_mixer a2_audio_props #(
    .AUDIO_DIVIDE  (0),
    .CHECK_SAMPLES (1'b1)
) i_mixer_props (
    .clk_pixel_w      (clk_pixel_w),
    .system_reset_n_w (system_reset_n_w),
    .tick_i           (tick_i),
    .sample_valid_i   (sample_valid_o),
    .sample_l_i       (sample_l_o),
    .sample_r_i       (sample_r_o)
);

// File: verif/tb_a2_audio.sv
module tb_a2_audio;

    timeunit 1ns;
    timeprecision 100ps;

    import a2_audio_pkg::*;

    localparam int CLOCK_SPEED_HZ = 4_410_000;
    localparam int AUDIO_RATE     = 44100;
    localparam bit SPEAKER_ON     = 1'b1;

    // Expected behavior of the card as seen on its pins
    localparam int                DIVIDE         = 100;
    localparam int                PHI1_HALF      = 20;
    localparam int                MB_POS         = 4;
    localparam logic [ADDR_W-1:0] SPEAKER_SWITCH = 16'hC030;
    localparam logic [31:0]       SPEAKER_TERM   = 32'h2000;
    localparam int                PULSE_LEN      = 255;
    localparam int                NUM_ROWS       = 9;

    logic                  clk_pixel_w;
    logic                  system_reset_n_w;
    logic                  a2_phi1;
    logic [ADDR_W-1:0]     a2_addr;
    logic                  a2_m2sel_n;
    logic [MB_AUDIO_W-1:0] mb_audio_l;
    logic [MB_AUDIO_W-1:0] mb_audio_r;
    logic [SAMPLE_W-1:0]   sample_l;
    logic [SAMPLE_W-1:0]   sample_r;
    logic                  sample_valid;

    // Stimulus table with one row per test
    logic [MB_AUDIO_W-1:0] row_mb_l    [NUM_ROWS];
    logic [MB_AUDIO_W-1:0] row_mb_r    [NUM_ROWS];
    bit                    row_random  [NUM_ROWS];
    int                    row_bus     [NUM_ROWS];
    logic [ADDR_W-1:0]     row_addr    [NUM_ROWS];
    bit                    row_m2sel_n [NUM_ROWS];
    int                    row_ticks   [NUM_ROWS];
    bit                    row_term    [NUM_ROWS];
    string                 row_desc    [NUM_ROWS];

    // Reference model of the speaker path
    logic       model_bit;
    logic       model_prev;
    int         model_count;
    logic       model_pulse;

    int          cycle_count      = 0;
    int          cycle_limit      = 1_000_000;
    int          release_cycle    = 0;
    int          last_valid_cycle = -1;
    int          check_count      = 0;
    int          error_count      = 0;
    int          failed_rows      = 0;
    logic [31:0] rng_state        = 32'd55354;

    a2_audio_top #(
        .CLOCK_SPEED_HZ (CLOCK_SPEED_HZ),
        .AUDIO_RATE     (AUDIO_RATE),
        .SPEAKER_ENABLE (SPEAKER_ON)
    ) i_a2_audio_top (
        .clk_pixel_w      (clk_pixel_w),
        .system_reset_n_w (system_reset_n_w),
        .a2_phi1_i        (a2_phi1),
        .a2_addr_i        (a2_addr),
        .a2_m2sel_n_i     (a2_m2sel_n),
        .mb_audio_l_i     (mb_audio_l),
        .mb_audio_r_i     (mb_audio_r),
        .sample_l_o       (sample_l),
        .sample_r_o       (sample_r),
        .sample_valid_o   (sample_valid)
    );

    initial clk_pixel_w = 1'b0;
    always #20 clk_pixel_w = ~clk_pixel_w;

    always @(posedge clk_pixel_w) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] t=%0d ns %s: got 0x%h, expected 0x%h",
                     $time, name, actual, expected);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic load_row(input int idx, input logic [MB_AUDIO_W-1:0] mb_l,
                            input logic [MB_AUDIO_W-1:0] mb_r, input bit rnd,
                            input int bus, input logic [ADDR_W-1:0] addr,
                            input bit m2sel_n, input int ticks, input bit term,
                            input string desc);
        row_mb_l[idx]    = mb_l;
        row_mb_r[idx]    = mb_r;
        row_random[idx]  = rnd;
        row_bus[idx]     = bus;
        row_addr[idx]    = addr;
        row_m2sel_n[idx] = m2sel_n;
        row_ticks[idx]   = ticks;
        row_term[idx]    = term;
        row_desc[idx]    = desc;
    endtask

    // Waits for the next strobe, checks the pair, then steps the speaker model
    task automatic take_sample();
        logic [31:0] term;
        logic        next_pulse;
        @(negedge clk_pixel_w);
        while (sample_valid !== 1'b1) begin
            @(negedge clk_pixel_w);
        end
        if (last_valid_cycle < 0) begin
            check_value("first_valid_cycle", cycle_count - release_cycle, DIVIDE + 1);
        end else begin
            check_value("valid_spacing", cycle_count - last_valid_cycle, DIVIDE);
        end
        last_valid_cycle = cycle_count;
        term = model_pulse ? SPEAKER_TERM : 32'h0;
        check_value("sample_l_o", sample_l, (32'(mb_audio_l) << MB_POS) + term);
        check_value("sample_r_o", sample_r, (32'(mb_audio_r) << MB_POS) + term);
        // Pulse is judged on the state before this tick
        next_pulse = SPEAKER_ON && model_prev && (model_count != 0);
        if (model_bit != model_prev) begin
            model_count = PULSE_LEN;
        end else if (model_count != 0) begin
            model_count = model_count - 1;
        end
        model_prev  = model_bit;
        model_pulse = next_pulse;
    endtask

    // One Phi1 period with the address held for all of it
    task automatic bus_cycle(input logic [ADDR_W-1:0] addr, input bit m2sel_n);
        a2_addr    = addr;
        a2_m2sel_n = m2sel_n;
        a2_phi1    = 1'b1;
        if (addr == SPEAKER_SWITCH && !m2sel_n) begin
            model_bit = ~model_bit;
        end
        repeat (PHI1_HALF) @(negedge clk_pixel_w);
        a2_phi1 = 1'b0;
        repeat (PHI1_HALF) @(negedge clk_pixel_w);
        a2_addr    = '0;
        a2_m2sel_n = 1'b1;
    endtask

    initial begin
        int total_ticks;
        int errors_before;
        a2_phi1          = 1'b0;
        a2_addr          = '0;
        a2_m2sel_n       = 1'b1;
        mb_audio_l       = '0;
        mb_audio_r       = '0;
        system_reset_n_w = 1'b1;
        model_bit        = 1'b0;
        model_prev       = 1'b0;
        model_count      = 0;
        model_pulse      = 1'b0;

        load_row(0, 10'h000, 10'h000, 0, 0, 16'h0000, 1, 3, 0, "idle after reset");
        load_row(1, 10'h155, 10'h2AA, 0, 0, 16'h0000, 1, 4, 0, "mockingboard only");
        load_row(2, 10'h000, 10'h000, 1, 0, 16'h0000, 1, 4, 0, "random mockingboard");
        load_row(3, 10'h100, 10'h040, 0, 1, 16'hC030, 0, 6, 1, "one speaker access");
        load_row(4, 10'h000, 10'h000, 1, 3, 16'hC031, 0, 4, 1, "other address");
        load_row(5, 10'h3FF, 10'h001, 0, 2, 16'hC030, 1, 4, 1, "m2sel high");
        load_row(6, 10'h0C0, 10'h300, 0, 1, 16'hC030, 0, 4, 0, "second access");
        load_row(7, 10'h020, 10'h3E0, 0, 3, 16'hC030, 0, 262, 0, "held speaker level");
        load_row(8, 10'h000, 10'h000, 1, 0, 16'h0000, 1, 4, 0, "random after pulse");

        // Each bus cycle uses up one tick and the first strobe after reset adds one more
        total_ticks = 1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_ticks += row_bus[r] + row_ticks[r];
        end
        cycle_limit = total_ticks * DIVIDE + 1000;

        // Reset from the first falling edge for two cycles
        @(negedge clk_pixel_w);
        system_reset_n_w = 1'b0;
        repeat (2) @(negedge clk_pixel_w);
        system_reset_n_w = 1'b1;
        release_cycle = cycle_count;
        check_value("sample_valid_o", sample_valid, 0);
        check_value("sample_l_o", sample_l, 0);
        check_value("sample_r_o", sample_r, 0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            errors_before = error_count;
            if (row_random[r]) begin
                rng_state  = xorshift32(rng_state);
                mb_audio_l = rng_state[MB_AUDIO_W-1:0];
                rng_state  = xorshift32(rng_state);
                mb_audio_r = rng_state[MB_AUDIO_W-1:0];
            end else begin
                mb_audio_l = row_mb_l[r];
                mb_audio_r = row_mb_r[r];
            end
            // Bus cycles start right after a strobe and end well before the next tick
            for (int b = 0; b < row_bus[r]; b++) begin
                take_sample();
                bus_cycle(row_addr[r], row_m2sel_n[r]);
            end
            repeat (row_ticks[r]) take_sample();
            check_value("speaker_term", sample_l - (32'(mb_audio_l) << MB_POS),
                        row_term[r] ? SPEAKER_TERM : 32'h0);
            if (error_count == errors_before) begin
                $display("Row %0d, %s: ok", r, row_desc[r]);
            end else begin
                failed_rows++;
                $display("Row %0d, %s: %0d errors", r, row_desc[r],
                         error_count - errors_before);
            end
        end

        $display("Rows %0d, failed rows %0d, checks %0d, errors %0d",
                 NUM_ROWS, failed_rows, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
